// File: Makefile
# Verilator build and run of the trace cache testbench

VERILATOR ?= verilator
TOP       ?= tb_trace_cache
FLIST     ?= trace_cache.f
MDIR      ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(MDIR) -f $(FLIST)

run: compile
	-./$(MDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "TB PASSED" $(LOG) || { echo "simulation ended without a pass line"; exit 1; }

clean:
	rm -rf $(MDIR) $(LOG)

// File: tb_clock_gen.sv
/*
 * testbench clock and reset
 *   100 ns clock, reset held low for two cycles
 */
`timescale 1ns/1ns

module tb_clock_gen (
        output logic    clk,
        output logic    rst_n
);

        initial begin
                clk = 1'b0;
                forever #50 clk = ~clk;
        end

        initial begin
                rst_n = 1'b0;
                repeat (2) @(posedge clk);
                @(negedge clk);
                rst_n = 1'b1;           // released on a falling edge
        end

endmodule

// File: tb_trace_cache.sv
/*
 * trace cache testbench
 *   LFSR retire groups, reference trap cut and successor pc
 *   line model with usage counters, compare process and typed compare tasks
 */
`timescale 1ns/1ns
`include "trace_cache_config.svh"

module tb_trace_cache
        import trace_types_pkg::*;
        import trace_ctrl_pkg::*;
();

        logic clk, rst_n;
        logic trace_enable, invalidate, pc_used, rename_stall, retire_valid;
        cpu_mode_t cpu_mode;
        scale_t trace_scale;
        va_t pc;
        slot_mask_t retire_mask, retire_trap, retire_short, retire_taken;
        va_t [`TC_NRETIRE-1:0] retire_pc, retire_dest;
        insn_t [`TC_NRETIRE-1:0] retire_insn;
        logic trace_hit;
        slot_mask_t trace_valid;
        va_t [`TC_NRETIRE-1:0] trace_pc;
        insn_t [`TC_NRETIRE-1:0] trace_insn;
        va_t pc_next;

        // line model
        slot_mask_t m_valid [`TC_NUM_LINES];
        va_t m_tag [`TC_NUM_LINES];
        va_t m_next [`TC_NUM_LINES];
        va_t [`TC_NRETIRE-1:0] m_pc [`TC_NUM_LINES];
        insn_t [`TC_NRETIRE-1:0] m_insn [`TC_NUM_LINES];
        use_cnt_t m_use [`TC_NUM_LINES];
        logic m_on;                     // fill FSM expected in run

        logic [15:0] lfsr = 16'd38;
        int n_grp = 0;
        string cmp_name;
        int cmp_idx;                    // model line behind the outputs or -1 on a miss
        logic cmp_hit;
        event do_cmp;

        tb_clock_gen clkgen (.clk(clk), .rst_n(rst_n));
        trace_cache_top UUT (.*);

        function automatic logic [31:0] rand_bits(input int n);
                logic [31:0] v;
                logic fb;
                v = '0;
                for (int i = 0; i < n; i++) begin
                        fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
                        lfsr = {lfsr[14:0], fb};
                        v = {v[30:0], fb};
                end
                return v;
        endfunction

        function automatic va_t fresh_pc();
                n_grp++;
                return va_t'({20'(rand_bits(20)), 10'(n_grp), 2'b00});   // index keeps it unique
        endfunction

        // every trapping valid slot cuts itself and the slots above it
        function automatic void ref_group(input slot_mask_t mask, trap, shrt, taken,
                        input va_t [`TC_NRETIRE-1:0] pcs, dst,
                        output slot_mask_t kept, output va_t nxt);
                int last;
                kept = mask;
                for (int i = 0; i < `TC_NRETIRE; i++)
                        if (mask[i] && trap[i])
                                kept = kept & slot_mask_t'((1 << i) - 1);
                last = -1;
                for (int i = 0; i < `TC_NRETIRE; i++)
                        if (kept[i])
                                last = i;
                nxt = '0;
                if (last >= 0)
                        nxt = taken[last] ? dst[last] :
                                pcs[last] + (shrt[last] ? va_t'(2) : va_t'(4));
        endfunction

        function automatic int model_find(input va_t p);
                for (int l = 0; l < `TC_NUM_LINES; l++)
                        if (m_valid[l][0] && m_tag[l] == p)
                                return l;
                return -1;
        endfunction

        function automatic void model_clear();
                for (int l = 0; l < `TC_NUM_LINES; l++) begin
                        m_valid[l] = '0;
                        m_use[l] = '0;
                end
        endfunction

        function automatic void model_decay(input int ticks);
                for (int l = 0; l < `TC_NUM_LINES; l++)
                        m_use[l] = m_use[l] > use_cnt_t'(ticks) ? m_use[l] - use_cnt_t'(ticks) : '0;
        endfunction

        task automatic fail_stop(input string why);
                $display("%s", why);
                $display("TB FAILED");
                $fatal(1, "stopped at the first error");
        endtask

        task automatic check_mask(input string name, input slot_mask_t exp, input slot_mask_t got);
                if (got !== exp)
                        fail_stop($sformatf("Fail %s expected %h actual %h", name, exp, got));
        endtask

        task automatic check_va(input string name, input va_t exp, input va_t got);
                if (got !== exp)
                        fail_stop($sformatf("Fail %s expected %h actual %h", name, exp, got));
        endtask

        task automatic check_insn(input string name, input insn_t exp, input insn_t got);
                if (got !== exp)
                        fail_stop($sformatf("Fail %s expected %h actual %h", name, exp, got));
        endtask

        task automatic check_hit(input string name, input logic exp, input logic got);
                if (got !== exp)
                        fail_stop($sformatf("Fail %s expected %b actual %b", name, exp, got));
        endtask

        // drives one group on the retire port and applies the write decision to the model
        task automatic send_group(input va_t start, input int n, input int trap_at);
                slot_mask_t m, tr, sh, tk, kept;
                va_t [`TC_NRETIRE-1:0] pcs, dst;
                insn_t [`TC_NRETIRE-1:0] ins;
                va_t cur, nxt;
                int l;
                cur = start;
                for (int i = 0; i < `TC_NRETIRE; i++) begin
                        m[i] = i < n;
                        tr[i] = i == trap_at;
                        sh[i] = rand_bits(1) != 0;
                        tk[i] = rand_bits(2) == 0;      // roughly one slot in four taken
                        dst[i] = va_t'(rand_bits(30)) << 2;
                        ins[i] = insn_t'(rand_bits(32));
                        pcs[i] = cur;
                        cur = tk[i] ? dst[i] : cur + (sh[i] ? va_t'(2) : va_t'(4));
                end
                ref_group(m, tr, sh, tk, pcs, dst, kept, nxt);
                @(negedge clk);
                retire_valid <= 1'b1;
                retire_mask <= m;
                retire_trap <= tr;
                retire_short <= sh;
                retire_taken <= tk;
                retire_pc <= pcs;
                retire_dest <= dst;
                retire_insn <= ins;
                if (m_on && kept[0] && model_find(start) < 0) begin
                        l = -1;
                        for (int k = `TC_NUM_LINES - 1; k >= 0; k--)
                                if (m_use[k] == '0)
                                        l = k;
                        if (l >= 0) begin
                                m_valid[l] = kept;
                                m_tag[l] = start;
                                m_next[l] = nxt;
                                m_pc[l] = pcs;
                                m_insn[l] = ins;
                                m_use[l] = use_cnt_t'(`TC_USE_ALLOC);
                        end
                end
        endtask

        task automatic end_groups();
                @(negedge clk);
                retire_valid <= 1'b0;
        endtask

        task automatic sample(input string name, input int idx);
                @(posedge clk);
                @(negedge clk);
                cmp_name = name;
                cmp_idx = idx;
                cmp_hit = model_find(pc) >= 0;
                -> do_cmp;
        endtask

        task automatic lookup(input va_t p, input string name);
                @(negedge clk);
                pc <= p;
                sample(name, model_find(p));
        endtask

        // compare process
        always begin
                @(do_cmp);
                check_hit({cmp_name, " hit"}, cmp_hit, trace_hit);
                if (cmp_idx < 0) begin
                        check_mask({cmp_name, " mask"}, '0, trace_valid);
                end else begin
                        check_mask({cmp_name, " mask"}, m_valid[cmp_idx], trace_valid);
                        check_va({cmp_name, " pc_next"}, m_next[cmp_idx], pc_next);
                        for (int i = 0; i < `TC_NRETIRE; i++) begin
                                if (m_valid[cmp_idx][i]) begin
                                        check_va($sformatf("%s pc%0d", cmp_name, i),
                                                m_pc[cmp_idx][i], trace_pc[i]);
                                        check_insn($sformatf("%s insn%0d", cmp_name, i),
                                                m_insn[cmp_idx][i], trace_insn[i]);
                                end
                        end
                end
        end

        always @(UUT.u_chk.n_fail)
                if (UUT.u_chk.n_fail != 0)
                        fail_stop("an assertion in the bound checker failed");

        initial begin
                va_t starts [10];
                va_t extra;
                int w;
                trace_enable = 1'b1;
                invalidate = 1'b0;
                cpu_mode = '0;
                trace_scale = 4'hf;
                pc = '0;
                pc_used = 1'b1;
                rename_stall = 1'b0;
                retire_valid = 1'b0;
                retire_mask = '0;
                retire_trap = '0;
                retire_short = '0;
                retire_taken = '0;
                retire_pc = '0;
                retire_dest = '0;
                retire_insn = '0;
                model_clear();
                m_on = 1'b1;
                for (w = 0; w < 20 && rst_n !== 1'b1; w++)
                        @(posedge clk);
                if (rst_n !== 1'b1)
                        fail_stop("reset was not released within 20 cycles");

                lookup(fresh_pc(), "empty cache");
                lookup('0, "empty cache pc 0");

                for (int i = 0; i < 4; i++) begin
                        starts[i] = fresh_pc();
                        send_group(starts[i], 1 + int'(rand_bits(2)), -1);
                end
                end_groups();
                for (int i = 0; i < 4; i++)
                        lookup(starts[i], $sformatf("fill lookup %0d", i));

                starts[4] = fresh_pc();
                send_group(starts[4], 4, 2);
                starts[5] = fresh_pc();
                send_group(starts[5], 3, 0);            // nothing kept
                send_group(starts[1], 4, -1);           // already cached
                end_groups();
                lookup(starts[4], "trap cut");
                lookup(starts[5], "trap on slot 0");
                lookup(starts[1], "duplicate start");

                @(negedge clk);
                invalidate <= 1'b1;
                @(negedge clk);
                invalidate <= 1'b0;
                model_clear();
                lookup(starts[0], "after invalidate");
                lookup(starts[4], "after invalidate 2");

                pc_used <= 1'b0;
                for (int i = 0; i < 9; i++) begin
                        starts[i] = fresh_pc();
                        send_group(starts[i], 2, -1);
                end
                end_groups();
                lookup(starts[7], "eighth line");
                lookup(starts[8], "ninth start misses");
                @(negedge clk);
                trace_scale <= '0;
                repeat (40) @(negedge clk);
                model_decay(2);
                extra = fresh_pc();
                send_group(extra, 3, -1);
                end_groups();
                lookup(extra, "refill after decay");
                lookup(starts[0], "line 0 evicted");

                @(negedge clk);
                cpu_mode <= 4'h3;
                @(negedge clk);
                model_clear();
                lookup(extra, "after mode change");

                @(negedge clk);
                trace_enable <= 1'b0;
                model_clear();
                m_on = 1'b0;
                starts[0] = fresh_pc();
                send_group(starts[0], 4, -1);
                end_groups();
                lookup(starts[0], "disabled fill");
                @(negedge clk);
                trace_enable <= 1'b1;
                m_on = 1'b1;

                starts[1] = fresh_pc();
                send_group(starts[1], 4, -1);
                starts[2] = fresh_pc();
                send_group(starts[2], 2, -1);
                end_groups();
                lookup(starts[1], "before stall");
                @(negedge clk);
                rename_stall <= 1'b1;
                pc <= starts[2];
                sample("stall hold", model_find(starts[1]));
                sample("stall hold 2", model_find(starts[1]));
                @(negedge clk);
                rename_stall <= 1'b0;
                sample("after release", model_find(starts[2]));

                @(negedge clk);
                if (UUT.u_chk.n_fail == 0) begin
                        $display("TB PASSED");
                        $finish;
                end else begin
                        fail_stop("assertion failures were counted");
                end
        end

endmodule

// File: trace_cache.f
+incdir+.
trace_types_pkg.sv
trace_ctrl_pkg.sv
trace_retire_stage.sv
trace_fill_fsm.sv
trace_decay_timer.sv
trace_line_store.sv
trace_usage_ctrl.sv
trace_cache_top.sv
trace_cache_chk.sv
tb_clock_gen.sv
tb_trace_cache.sv

// File: trace_cache_chk.sv
/*
 * bound assertions on the trace cache outputs
 *   contiguous slot mask, hold under rename stall, no hit right after reset
 */
`timescale 1ns/1ns
`include "trace_cache_config.svh"

module trace_cache_chk
        import trace_types_pkg::*;
(
        input  logic                            clk,
        input  logic                            rst_n,
        input  logic                            rename_stall,
        input  logic                            trace_hit,
        input  slot_mask_t                      trace_valid,
        input  va_t [`TC_NRETIRE-1:0]           trace_pc,
        input  insn_t [`TC_NRETIRE-1:0]         trace_insn,
        input  va_t                             pc_next
);

        int n_fail = 0;         // failed assertion count

        // a kept mask is always 2**k - 1
        a_contig: assert property (@(posedge clk) disable iff (!rst_n)
                (trace_valid & slot_mask_t'(trace_valid + 1'b1)) == '0)
                else begin
                        $error("trace_valid is not contiguous from slot 0");
                        n_fail++;
                end

        a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
                rename_stall |=> $stable(trace_valid) && $stable(trace_pc) &&
                        $stable(trace_insn) && $stable(pc_next))
                else begin
                        $error("trace outputs moved while rename_stall was high");
                        n_fail++;
                end

        a_reset_hit: assert property (@(posedge clk) $rose(rst_n) |-> !trace_hit)
                else begin
                        $error("trace_hit high in the first cycle after reset");
                        n_fail++;
                end

endmodule

bind trace_cache_top trace_cache_chk u_chk (.*);

// File: trace_cache_config.svh
/*
 * trace cache build constants
 *   retire group width and line count
 *   address and instruction widths
 *   usage counter limits
 */
`ifndef TRACE_CACHE_CONFIG_SVH
`define TRACE_CACHE_CONFIG_SVH

`define TC_NRETIRE 4            // instructions per retire group and per line
`define TC_NUM_LINES 8          // fully associative lines

`define TC_VA_SZ 32             // byte address width
`define TC_INSN_SZ 32           // instruction word width

// usage counter values
`define TC_USE_ALLOC 2          // floor set when a line is written
`define TC_USE_MAX 7            // saturation point

`endif

// File: trace_cache_top.sv
/*
 * trace cache top level
 *   retire stage, fill FSM, decay timer
 *   line store and usage/replacement control
 */
`timescale 1ns/1ns
`include "trace_cache_config.svh"

module trace_cache_top
        import trace_types_pkg::*;
        import trace_ctrl_pkg::*;
(
        input  logic                            clk,
        input  logic                            rst_n,
        input  logic                            trace_enable,
        input  logic                            invalidate,
        input  cpu_mode_t                       cpu_mode,
        input  scale_t                          trace_scale,
        input  va_t                             pc,
        input  logic                            pc_used,
        input  logic                            rename_stall,
        input  logic                            retire_valid,
        input  slot_mask_t                      retire_mask,
        input  slot_mask_t                      retire_trap,
        input  slot_mask_t                      retire_short,
        input  slot_mask_t                      retire_taken,
        input  va_t [`TC_NRETIRE-1:0]           retire_pc,
        input  va_t [`TC_NRETIRE-1:0]           retire_dest,
        input  insn_t [`TC_NRETIRE-1:0]         retire_insn,
        output logic                            trace_hit,
        output slot_mask_t                      trace_valid,
        output va_t [`TC_NRETIRE-1:0]           trace_pc,
        output insn_t [`TC_NRETIRE-1:0]         trace_insn,
        output va_t                             pc_next
);

        logic                           grp_valid;
        slot_mask_t                     grp_mask;
        va_t                            grp_tag;
        va_t                            grp_next;
        va_t [`TC_NRETIRE-1:0]          grp_pc;
        insn_t [`TC_NRETIRE-1:0]        grp_insn;
        logic                           grp_tag_hit;
        logic                           victim_ok;
        line_idx_t                      victim;
        logic                           line_write;
        line_idx_t                      write_line;
        logic                           clear_all;
        line_mask_t                     hit_lines;
        logic                           decay_tick;

        trace_retire_stage u_retire (.*);
        trace_fill_fsm u_fill (.*);
        trace_decay_timer u_decay (.*);
        trace_line_store u_store (.*);
        trace_usage_ctrl u_usage (.*);

endmodule

// File: trace_ctrl_pkg.sv
/*
 * control types for the trace cache
 *   fill FSM states
 *   decay timer scale and count, cpu mode
 */
package trace_ctrl_pkg;

        typedef enum logic [1:0] {
                FILL_OFF,               // cache disabled
                FILL_RUN,               // normal fill
                FILL_CLEAR              // wiping all lines
        } fill_state_e;

        typedef logic [3:0] scale_t;
        typedef logic [8:0] decay_cnt_t;
        typedef logic [3:0] cpu_mode_t;

endpackage

// File: trace_decay_timer.sv
/*
 * usage decay timer
 *   reloadable down-counter, period set by the trace scale
 */
`timescale 1ns/1ns

module trace_decay_timer
        import trace_ctrl_pkg::*;
(
        input  logic    clk,
        input  logic    rst_n,
        input  scale_t  trace_scale,
        output logic    decay_tick
);

        scale_t         r_scale;
        decay_cnt_t     cnt;
        logic           scale_chg;

        // scale[1:0] then 4..7 ones, so 16 to 512 cycle periods
        function automatic decay_cnt_t reload_val(input scale_t s);
                case (s[3:2])
                2'b00:   reload_val = {3'b0, s[1:0], 4'hf};
                2'b01:   reload_val = {2'b0, s[1:0], 5'h1f};
                2'b10:   reload_val = {1'b0, s[1:0], 6'h3f};
                default: reload_val = {s[1:0], 7'h7f};
                endcase
        endfunction

        assign scale_chg = trace_scale != r_scale;
        assign decay_tick = cnt == '0 && !scale_chg;    // a scale change restarts silently

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        r_scale <= '0;
                        cnt <= decay_cnt_t'(9'h00f);    // matches scale 0
                end else begin
                        r_scale <= trace_scale;
                        if (cnt == '0 || scale_chg)
                                cnt <= reload_val(trace_scale);
                        else
                                cnt <= cnt - 1'b1;
                end
        end

endmodule

// File: trace_fill_fsm.sv
/*
 * fill FSM
 *   off / run / clear sequencing from enable, invalidate and cpu mode
 *   write decision for each decoded retire group
 */
`timescale 1ns/1ns

module trace_fill_fsm
        import trace_types_pkg::*;
        import trace_ctrl_pkg::*;
(
        input  logic            clk,
        input  logic            rst_n,
        input  logic            trace_enable,
        input  logic            invalidate,
        input  cpu_mode_t       cpu_mode,
        input  logic            grp_valid,
        input  logic            grp_tag_hit,
        input  logic            victim_ok,
        input  line_idx_t       victim,
        output logic            line_write,
        output line_idx_t       write_line,
        output logic            clear_all
);

        fill_state_e    state;
        fill_state_e    state_nxt;
        cpu_mode_t      r_cpu_mode;

        always_comb begin
                if (!trace_enable)
                        state_nxt = FILL_OFF;
                else if (invalidate || cpu_mode != r_cpu_mode)  // any mode switch wipes
                        state_nxt = FILL_CLEAR;
                else
                        state_nxt = FILL_RUN;
        end

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        state <= FILL_RUN;
                        r_cpu_mode <= '0;
                end else begin
                        state <= state_nxt;
                        r_cpu_mode <= cpu_mode;
                end
        end

        // off also wipes, so valid bits stay clear while disabled
        assign clear_all = state != FILL_RUN;

        // new start pc only, and only into a free line
        assign line_write = state == FILL_RUN && grp_valid && !grp_tag_hit && victim_ok;
        assign write_line = victim;

endmodule

// File: trace_line_store.sv
/*
 * trace line storage
 *   tag, slot mask, successor and slot data arrays
 *   associative lookup and fill tag match
 *   one-hot read mux into stall-held output registers
 */
`timescale 1ns/1ns
`include "trace_cache_config.svh"

module trace_line_store
        import trace_types_pkg::*;
(
        input  logic                            clk,
        input  logic                            rst_n,
        input  logic                            clear_all,
        input  logic                            line_write,
        input  line_idx_t                       write_line,
        input  slot_mask_t                      grp_mask,
        input  va_t                             grp_tag,
        input  va_t                             grp_next,
        input  va_t [`TC_NRETIRE-1:0]           grp_pc,
        input  insn_t [`TC_NRETIRE-1:0]         grp_insn,
        input  va_t                             pc,
        input  logic                            rename_stall,
        output logic                            grp_tag_hit,
        output line_mask_t                      hit_lines,
        output logic                            trace_hit,
        output slot_mask_t                      trace_valid,
        output va_t [`TC_NRETIRE-1:0]           trace_pc,
        output insn_t [`TC_NRETIRE-1:0]         trace_insn,
        output va_t                             pc_next
);

        slot_mask_t             r_valid [`TC_NUM_LINES];
        va_t                    r_tag [`TC_NUM_LINES];
        va_t                    r_next [`TC_NUM_LINES];
        va_t [`TC_NRETIRE-1:0]  r_pc [`TC_NUM_LINES];
        insn_t [`TC_NRETIRE-1:0] r_insn [`TC_NUM_LINES];

        line_mask_t             fill_match;
        slot_mask_t             rd_valid;
        va_t [`TC_NRETIRE-1:0]  rd_pc;
        insn_t [`TC_NRETIRE-1:0] rd_insn;
        va_t                    rd_next;

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        for (int l = 0; l < `TC_NUM_LINES; l++)
                                r_valid[l] <= '0;
                end else begin
                        for (int l = 0; l < `TC_NUM_LINES; l++) begin
                                if (clear_all)
                                        r_valid[l] <= '0;
                                else if (line_write && write_line == line_idx_t'(l))
                                        r_valid[l] <= grp_mask;
                        end
                end
        end

        always_ff @(posedge clk) begin
                if (line_write) begin
                        r_tag[write_line] <= grp_tag;
                        r_next[write_line] <= grp_next;
                        r_pc[write_line] <= grp_pc;
                        r_insn[write_line] <= grp_insn;
                end
        end

        // both matches need slot 0 valid
        always_comb begin
                for (int l = 0; l < `TC_NUM_LINES; l++) begin
                        hit_lines[l] = r_valid[l][0] && r_tag[l] == pc;
                        fill_match[l] = r_valid[l][0] && r_tag[l] == grp_tag;
                end
        end

        assign trace_hit = |hit_lines;
        assign grp_tag_hit = |fill_match;

        // at most one line matches, so an OR of gated lines is the mux
        always_comb begin
                rd_valid = '0;
                rd_pc = '0;
                rd_insn = '0;
                rd_next = '0;
                for (int l = 0; l < `TC_NUM_LINES; l++) begin
                        if (hit_lines[l]) begin
                                rd_valid = rd_valid | r_valid[l];
                                rd_pc = rd_pc | r_pc[l];
                                rd_insn = rd_insn | r_insn[l];
                                rd_next = rd_next | r_next[l];
                        end
                end
        end

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n)
                        trace_valid <= '0;
                else if (!rename_stall)
                        trace_valid <= rd_valid;        // zero on a miss
        end

        always_ff @(posedge clk) begin
                if (!rename_stall) begin
                        trace_pc <= rd_pc;
                        trace_insn <= rd_insn;
                        pc_next <= rd_next;
                end
        end

endmodule

// File: trace_retire_stage.sv
/*
 * retire group stage
 *   registers each retire group
 *   trap cut of the slot mask
 *   successor pc from the last kept slot
 */
`timescale 1ns/1ns
`include "trace_cache_config.svh"

module trace_retire_stage
        import trace_types_pkg::*;
(
        input  logic                            clk,
        input  logic                            rst_n,
        input  logic                            retire_valid,
        input  slot_mask_t                      retire_mask,
        input  slot_mask_t                      retire_trap,
        input  slot_mask_t                      retire_short,
        input  slot_mask_t                      retire_taken,
        input  va_t [`TC_NRETIRE-1:0]           retire_pc,
        input  va_t [`TC_NRETIRE-1:0]           retire_dest,
        input  insn_t [`TC_NRETIRE-1:0]         retire_insn,
        output logic                            grp_valid,
        output slot_mask_t                      grp_mask,
        output va_t                             grp_tag,
        output va_t                             grp_next,
        output va_t [`TC_NRETIRE-1:0]           grp_pc,
        output insn_t [`TC_NRETIRE-1:0]         grp_insn
);

        logic           r_valid;
        slot_mask_t     r_mask;
        slot_mask_t     r_trap;
        slot_mask_t     r_short;
        slot_mask_t     r_taken;
        va_t [`TC_NRETIRE-1:0] r_dest;

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n)
                        r_valid <= 1'b0;
                else
                        r_valid <= retire_valid;
        end

        always_ff @(posedge clk) begin
                r_mask <= retire_mask;
                r_trap <= retire_trap;
                r_short <= retire_short;
                r_taken <= retire_taken;
                r_dest <= retire_dest;
                grp_pc <= retire_pc;
                grp_insn <= retire_insn;
        end

        // drop the first trapping slot and everything after it
        always_comb begin
                logic seen_trap;
                seen_trap = 1'b0;
                for (int i = 0; i < `TC_NRETIRE; i++) begin
                        seen_trap = seen_trap | (r_trap[i] & r_mask[i]);
                        grp_mask[i] = r_mask[i] & ~seen_trap;
                end
        end

        // kept mask is a prefix, so the highest kept slot wins
        always_comb begin
                grp_next = grp_pc[0];
                for (int i = 0; i < `TC_NRETIRE; i++) begin
                        if (grp_mask[i])
                                grp_next = r_taken[i] ? r_dest[i] :
                                        grp_pc[i] + (r_short[i] ? va_t'(2) : va_t'(4));
                end
        end

        assign grp_valid = r_valid & grp_mask[0];
        assign grp_tag = grp_pc[0];

endmodule

// File: trace_types_pkg.sv
/*
 * datapath types for the trace cache
 *   addresses and instruction words
 *   per-slot and per-line masks
 *   line index and usage counter
 */
`include "trace_cache_config.svh"

package trace_types_pkg;

        typedef logic [`TC_VA_SZ-1:0] va_t;
        typedef logic [`TC_INSN_SZ-1:0] insn_t;

        // one bit per slot, slot 0 in bit 0
        typedef logic [`TC_NRETIRE-1:0] slot_mask_t;

        // one bit per line
        typedef logic [`TC_NUM_LINES-1:0] line_mask_t;
        typedef logic [$clog2(`TC_NUM_LINES)-1:0] line_idx_t;

        typedef logic [2:0] use_cnt_t;  // replacement usage count

endpackage

// File: trace_usage_ctrl.sv
/*
 * line usage and replacement
 *   per-line usage counters with write/hit/decay priority
 *   free vector and lowest free victim
 */
`timescale 1ns/1ns
`include "trace_cache_config.svh"

module trace_usage_ctrl
        import trace_types_pkg::*;
(
        input  logic            clk,
        input  logic            rst_n,
        input  logic            clear_all,
        input  logic            line_write,
        input  line_idx_t       write_line,
        input  line_mask_t      hit_lines,
        input  logic            pc_used,
        input  logic            rename_stall,
        input  logic            decay_tick,
        output logic            victim_ok,
        output line_idx_t       victim
);

        use_cnt_t       r_use [`TC_NUM_LINES];
        line_mask_t     r_hit;          // lines behind the current trace outputs
        line_mask_t     free;

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        r_hit <= '0;
                        for (int l = 0; l < `TC_NUM_LINES; l++)
                                r_use[l] <= '0;
                end else begin
                        if (clear_all)
                                r_hit <= '0;
                        else if (!rename_stall)
                                r_hit <= hit_lines;
                        for (int l = 0; l < `TC_NUM_LINES; l++) begin
                                if (clear_all) begin
                                        r_use[l] <= '0;
                                end else if (line_write && write_line == line_idx_t'(l)) begin
                                        if (r_use[l] < use_cnt_t'(`TC_USE_ALLOC))
                                                r_use[l] <= use_cnt_t'(`TC_USE_ALLOC);
                                end else if (r_hit[l] && pc_used && !decay_tick) begin
                                        if (r_use[l] != use_cnt_t'(`TC_USE_MAX))
                                                r_use[l] <= r_use[l] + 1'b1;
                                end else if (decay_tick && r_use[l] != '0) begin
                                        r_use[l] <= r_use[l] - 1'b1;
                                end
                        end
                end
        end

        always_comb begin
                victim = '0;
                for (int l = `TC_NUM_LINES - 1; l >= 0; l--) begin
                        free[l] = r_use[l] == '0;
                        if (free[l])
                                victim = line_idx_t'(l);        // lowest index ends up last
                end
        end

        assign victim_ok = |free;

endmodule
